// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= elink_ctrl_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= list.f

SOURCES := $(shell cat $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "Test completed successfully" $(LOG) || { echo "Simulation ended early"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: list.f
source/elink_pkg.sv
source/wb_memif.sv
source/ecfg.sv
source/embox.sv
source/emon_counter.sv
source/mi_readmux.sv
source/elink_ctrl.sv
testbench/elink_ctrl_tb.sv

// File: source/ecfg.sv
`default_nettype none

module ecfg
   import elink_pkg::*;
(
   input  logic      clk,
   input  logic      rst,                                // Hardware reset
   input  mi_req_t   mi,
   output mi_data_t  cfg_rdata,                          // Combinational readback
   output logic      ecfg_reset,                         // Block reset for link logic
   output ecfg_tx_t  tx_cfg,
   output ecfg_rx_t  rx_cfg,
   output ecfg_clk_t clk_cfg
);

   logic cfg_wr;                                         // Register write this cycle
   logic sw_reset;                                       // Software reset pulse

   assign cfg_wr = mi.access & mi.write;

   // Config fields survive a software reset, only rst clears them
   always_ff @(posedge clk) begin
      if (rst) begin
         tx_cfg   <= '0;
         rx_cfg   <= '0;
         clk_cfg  <= '0;
         sw_reset <= 1'b0;
      end else begin
         sw_reset <= cfg_wr && (mi.addr == ECFG_RESET) && mi.data[0]; // Self clearing
         if (cfg_wr) begin
            case (mi.addr)
               ECFG_TX: begin
                  tx_cfg <= mi.data[$bits(ecfg_tx_t)-1:0];      // Upper bits dropped
               end
               ECFG_RX: begin
                  rx_cfg <= mi.data[$bits(ecfg_rx_t)-1:0];
               end
               ECFG_CLK: begin
                  clk_cfg <= mi.data[$bits(ecfg_clk_t)-1:0];
               end
               default: begin
                  // Core id and reset register hold nothing
               end
            endcase
         end
      end
   end

   // Pulse lasts one cycle after the write, rst covers power-up
   assign ecfg_reset = rst | sw_reset;

   // Readback of current address, zero-extended fields
   always_comb begin
      cfg_rdata = '0;
      case (mi.addr)
         ECFG_TX: begin
            cfg_rdata[$bits(ecfg_tx_t)-1:0] = tx_cfg;
         end
         ECFG_RX: begin
            cfg_rdata[$bits(ecfg_rx_t)-1:0] = rx_cfg;
         end
         ECFG_CLK: begin
            cfg_rdata[$bits(ecfg_clk_t)-1:0] = clk_cfg;
         end
         ECFG_COREID: begin
            cfg_rdata[COREID_W-1:0] = CFG_COREID;        // Fixed chip coordinate
         end
         default: begin
            cfg_rdata = '0;                              // ECFG_RESET and holes
         end
      endcase
   end

endmodule

`default_nettype wire

// File: source/elink_ctrl.sv
`default_nettype none

module elink_ctrl
   import elink_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,                    // Synchronous, active high
   // Wishbone classic slave
   input  logic                  wb_cyc,
   input  logic                  wb_stb,
   input  logic                  wb_we,
   input  mi_addr_t              wb_addr,
   input  mi_data_t              wb_wdata,
   output logic                  wb_ack,
   output mi_data_t              wb_rdata,
   // Link activity
   input  link_events_t          events,                 // One-cycle access pulses
   // Link control
   output ecfg_tx_t              tx_cfg,
   output ecfg_rx_t              rx_cfg,
   output ecfg_clk_t             clk_cfg,
   // Interrupts
   output logic                  embox_full,
   output logic                  embox_not_empty,
   output logic [EMON_COUNT-1:0] emon_zero_flag
);

   mi_req_t               mi;                            // Shared register request
   mi_data_t              cfg_rdata;
   mi_data_t              mbox_rdata;
   count_t                emon_count [EMON_COUNT];
   logic                  ecfg_reset;                    // Block reset, hw or sw
   logic [EMON_COUNT-1:0] emon_load;                     // Per counter write strobe

   wb_memif wb_memif_inst (
      .clk      (clk),
      .rst      (rst),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_addr  (wb_addr),
      .wb_wdata (wb_wdata),
      .wb_ack   (wb_ack),
      .mi       (mi)
   );

   ecfg ecfg_inst (
      .clk        (clk),
      .rst        (rst),
      .mi         (mi),
      .cfg_rdata  (cfg_rdata),
      .ecfg_reset (ecfg_reset),
      .tx_cfg     (tx_cfg),
      .rx_cfg     (rx_cfg),
      .clk_cfg    (clk_cfg)
   );

   embox embox_inst (
      .clk             (clk),
      .ecfg_reset      (ecfg_reset),
      .mi              (mi),
      .mbox_rdata      (mbox_rdata),
      .embox_full      (embox_full),
      .embox_not_empty (embox_not_empty)
   );

   // One counter per event bit, rx_rd first
   for (genvar i = 0; i < EMON_COUNT; i++) begin : g_emon
      assign emon_load[i] = mi.access & mi.write & (mi.addr == EMON_BASE + mi_addr_t'(4 * i));

      emon_counter emon_counter_inst (
         .clk         (clk),
         .ecfg_reset  (ecfg_reset),
         .load        (emon_load[i]),
         .load_value  (mi.data),                         // Full word load
         .event_pulse (events[i]),
         .count       (emon_count[i]),
         .zero_flag   (emon_zero_flag[i])
      );
   end

   mi_readmux mi_readmux_inst (
      .clk        (clk),
      .rst        (rst),
      .mi         (mi),
      .cfg_rdata  (cfg_rdata),
      .mbox_rdata (mbox_rdata),
      .emon_count (emon_count),
      .wb_rdata   (wb_rdata)
   );

endmodule

`default_nettype wire

// File: source/elink_pkg.sv
`default_nettype none

package elink_pkg;

   // Field widths
   localparam int MI_AW       = 20;                      // Register bus byte address
   localparam int MI_DW       = 32;                      // Register data word
   localparam int COREID_W    = 12;                      // Chip coordinate width
   localparam int CLKDIV_W    = 4;                       // Divider or PLL code
   localparam int COUNT_W     = 32;                      // Monitor counter width

   // Block sizes
   localparam int EMON_COUNT  = 6;                       // One counter per link event
   localparam int EMBOX_DEPTH = 4;                       // Mailbox entries
   localparam int EMBOX_PTR_W = $clog2(EMBOX_DEPTH);     // Mailbox pointer width
   localparam int EMON_IDX_W  = $clog2(EMON_COUNT);      // Counter select width

   typedef logic [MI_AW-1:0]    mi_addr_t;
   typedef logic [MI_DW-1:0]    mi_data_t;
   typedef logic [COREID_W-1:0] coreid_t;
   typedef logic [CLKDIV_W-1:0] clkdiv_t;
   typedef logic [COUNT_W-1:0]  count_t;

   localparam coreid_t CFG_COREID = 12'h808;             // Row 0x20, column 0x08

   // Register map, byte addresses
   localparam mi_addr_t ECFG_RESET   = 20'h00000;        // Write 1 to bit 0, reads zero
   localparam mi_addr_t ECFG_TX      = 20'h00004;
   localparam mi_addr_t ECFG_RX      = 20'h00008;
   localparam mi_addr_t ECFG_CLK     = 20'h0000C;
   localparam mi_addr_t ECFG_COREID  = 20'h00010;        // Read only
   localparam mi_addr_t EMBOX_DATA   = 20'h00020;        // Push on write, pop on read
   localparam mi_addr_t EMBOX_STATUS = 20'h00024;        // Occupancy
   localparam mi_addr_t EMON_BASE    = 20'h00040;        // Counter i at base + 4*i

   // One register bus access
   typedef struct packed {
      logic     access;                                  // Single-cycle strobe
      logic     write;                                   // 1 write, 0 read
      mi_addr_t addr;
      mi_data_t data;                                    // Write data
   } mi_req_t;

   // Field order gives enable at register bit 0
   typedef struct packed {
      clkdiv_t    clkdiv;                                // Bits 10:7
      logic [3:0] ctrl_mode;                             // Bits 6:3
      logic       gpio_mode;
      logic       mmu_mode;
      logic       enable;
   } ecfg_tx_t;

   typedef struct packed {
      logic loopback_mode;                               // Bit 3
      logic gpio_mode;
      logic mmu_mode;
      logic enable;                                      // Bit 0
   } ecfg_rx_t;

   typedef struct packed {
      clkdiv_t cclk_pllcfg;                              // Bits 8:5
      clkdiv_t cclk_div;                                 // Bits 4:1
      logic    cclk_en;                                  // Bit 0
   } ecfg_clk_t;

   // Bit i drives monitor counter i
   typedef struct packed {
      logic tx_wb;                                       // Bit 5
      logic tx_wr;
      logic tx_rd;
      logic rx_wb;
      logic rx_wr;
      logic rx_rd;                                       // Bit 0
   } link_events_t;

   typedef enum logic [1:0] {
      SEL_NONE,                                          // Unmapped, reads zero
      SEL_ECFG,
      SEL_EMBOX,
      SEL_EMON
   } rdsel_e;

endpackage

`default_nettype wire

// File: source/embox.sv
`default_nettype none

module embox
   import elink_pkg::*;
(
   input  logic     clk,
   input  logic     ecfg_reset,                          // Block reset, hw or sw
   input  mi_req_t  mi,
   output mi_data_t mbox_rdata,                          // Combinational readback
   output logic     embox_full,                          // Interrupt, no room left
   output logic     embox_not_empty                      // Interrupt, mail waiting
);

   mi_data_t               mem [EMBOX_DEPTH];            // Message storage
   logic [EMBOX_PTR_W-1:0] wr_ptr;                       // Next free slot
   logic [EMBOX_PTR_W-1:0] rd_ptr;                       // Oldest entry
   logic [EMBOX_PTR_W:0]   count;                        // Occupancy, 0 to depth
   logic                   push;
   logic                   pop;

   assign embox_full      = (count == (EMBOX_PTR_W+1)'(EMBOX_DEPTH));
   assign embox_not_empty = (count != '0);

   // Write to a full box is lost
   assign push = mi.access & mi.write & (mi.addr == EMBOX_DATA) & ~embox_full;

   // Read of empty box pops nothing
   assign pop  = mi.access & ~mi.write & (mi.addr == EMBOX_DATA) & embox_not_empty;

   always_ff @(posedge clk) begin
      if (ecfg_reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + EMBOX_PTR_W'(1);          // Wraps at depth
         end
         if (pop) begin
            rd_ptr <= rd_ptr + EMBOX_PTR_W'(1);
         end
         // Single bus, push and pop never meet
         if (push) begin
            count <= count + 1'b1;
         end else if (pop) begin
            count <= count - 1'b1;
         end
      end
   end

   // Storage, no reset
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= mi.data;
      end
   end

   // Head of queue seen before the popping edge
   always_comb begin
      mbox_rdata = '0;
      if (mi.addr == EMBOX_DATA) begin
         if (embox_not_empty) begin
            mbox_rdata = mem[rd_ptr];
         end
      end else if (mi.addr == EMBOX_STATUS) begin
         mbox_rdata[EMBOX_PTR_W:0] = count;              // Entries held
      end
   end

endmodule

`default_nettype wire

// File: source/emon_counter.sv
`default_nettype none

module emon_counter
   import elink_pkg::*;
(
   input  logic   clk,
   input  logic   ecfg_reset,                            // Clears count to zero
   input  logic   load,                                  // Software write of this counter
   input  count_t load_value,
   input  logic   event_pulse,                           // One link access
   output count_t count,
   output logic   zero_flag                              // Registered, count is zero
);

   count_t count_next;

   // Load beats event; count floors at zero
   always_comb begin
      count_next = count;
      if (load) begin
         count_next = load_value;
      end else if (event_pulse && (count != '0)) begin
         count_next = count - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (ecfg_reset) begin
         count     <= '0;
         zero_flag <= 1'b1;                              // Zero count after reset
      end else begin
         count     <= count_next;
         zero_flag <= (count_next == '0);                // Tracks count same edge
      end
   end

endmodule

`default_nettype wire

// File: source/mi_readmux.sv
`default_nettype none

module mi_readmux
   import elink_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  mi_req_t  mi,
   input  mi_data_t cfg_rdata,                           // From ecfg
   input  mi_data_t mbox_rdata,                          // From embox
   input  count_t   emon_count [EMON_COUNT],             // From counters
   output mi_data_t wb_rdata                             // Held until next read
);

   rdsel_e                rd_sel;                        // Source of this read
   mi_addr_t              emon_off;                      // Offset into counter window
   logic [EMON_IDX_W-1:0] emon_idx;                      // Counter number
   mi_data_t              rd_word;                       // Selected word

   assign emon_off = mi.addr - EMON_BASE;
   assign emon_idx = emon_off[EMON_IDX_W+1:2];           // Word index

   // Word aligned decode only
   always_comb begin
      rd_sel = SEL_NONE;
      if (mi.addr[1:0] == 2'b00) begin
         if (mi.addr <= ECFG_COREID) begin
            rd_sel = SEL_ECFG;
         end else if ((mi.addr == EMBOX_DATA) || (mi.addr == EMBOX_STATUS)) begin
            rd_sel = SEL_EMBOX;
         end else if ((mi.addr >= EMON_BASE) && (emon_off < mi_addr_t'(4 * EMON_COUNT))) begin
            rd_sel = SEL_EMON;
         end
      end
   end

   always_comb begin
      case (rd_sel)
         SEL_ECFG:  rd_word = cfg_rdata;
         SEL_EMBOX: rd_word = mbox_rdata;
         SEL_EMON:  rd_word = emon_count[emon_idx];
         default:   rd_word = '0;                        // Unmapped reads zero
      endcase
   end

   // Captured at the access edge, valid during ack
   always_ff @(posedge clk) begin
      if (rst) begin
         wb_rdata <= '0;
      end else if (mi.access && !mi.write) begin
         wb_rdata <= rd_word;
      end
   end

endmodule

`default_nettype wire

// File: source/wb_memif.sv
`default_nettype none

module wb_memif
   import elink_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  logic     wb_cyc,                              // Bus cycle in progress
   input  logic     wb_stb,                              // Slave select
   input  logic     wb_we,                               // Write enable
   input  mi_addr_t wb_addr,
   input  mi_data_t wb_wdata,
   output logic     wb_ack,                              // One-cycle acknowledge
   output mi_req_t  mi                                   // Internal register request
);

   logic bus_req;                                        // Master asking for a transfer
   logic first_cyc;                                      // First cycle of this strobe

   assign bus_req   = wb_cyc & wb_stb;

   // Ack low marks a fresh request; the ack cycle itself is
   // the tail of the previous transfer and must not re-issue it
   assign first_cyc = bus_req & ~wb_ack;

   // Ack follows the access by one clock, classic single cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         wb_ack <= 1'b0;
      end else begin
         wb_ack <= first_cyc;
      end
   end

   // Request is combinational from the held master signals
   always_comb begin
      mi.access = first_cyc;                             // Exactly one per bus cycle
      mi.write  = wb_we;
      mi.addr   = wb_addr;
      mi.data   = wb_wdata;
   end

endmodule

`default_nettype wire

// File: testbench/elink_ctrl_tb.sv
`default_nettype none

module elink_ctrl_tb
   import elink_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int    CLK_PERIOD     = 40;                   // ns
   localparam int    RESET_CYCLES   = 3;
   localparam int    CYCLES_PER_OP  = 20;                   // Watchdog budget per file line
   localparam int    ACK_LIMIT      = 8;                    // Cycles to wait for wb_ack
   localparam string TESTS_FILE     = "testbench/elink_ctrl_tests.txt";

   logic                  clk;
   logic                  rst;
   logic                  wb_cyc;
   logic                  wb_stb;
   logic                  wb_we;
   mi_addr_t              wb_addr;
   mi_data_t              wb_wdata;
   logic                  wb_ack;
   mi_data_t              wb_rdata;
   link_events_t          events;
   ecfg_tx_t              tx_cfg;
   ecfg_rx_t              rx_cfg;
   ecfg_clk_t             clk_cfg;
   logic                  embox_full;
   logic                  embox_not_empty;
   logic [EMON_COUNT-1:0] emon_zero_flag;

   int          line_total = 0;                             // Lines in tests file
   logic [15:0] lfsr_state;                                 // Idle gap generator

   elink_ctrl elink_ctrl_inst (
      .clk             (clk),
      .rst             (rst),
      .wb_cyc          (wb_cyc),
      .wb_stb          (wb_stb),
      .wb_we           (wb_we),
      .wb_addr         (wb_addr),
      .wb_wdata        (wb_wdata),
      .wb_ack          (wb_ack),
      .wb_rdata        (wb_rdata),
      .events          (events),
      .tx_cfg          (tx_cfg),
      .rx_cfg          (rx_cfg),
      .clk_cfg         (clk_cfg),
      .embox_full      (embox_full),
      .embox_not_empty (embox_not_empty),
      .emon_zero_flag  (emon_zero_flag)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   // 16 bit Fibonacci with taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic fail_run(input string what);
      $display("%s", what);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected) else begin
         $display("** Error %s: expected %h, actual %h", name, expected, actual);
         $display("Test failed");
         $fatal(1);
      end
   endtask

   // 0 to 3 idle clocks from two LFSR steps
   task automatic idle_gap();
      int gap;
      gap = 0;
      repeat (2) begin
         lfsr_state = lfsr_next(lfsr_state);
         gap        = (gap << 1) | int'(lfsr_state[0]);
      end
      repeat (gap) @(posedge clk);
   endtask

   // One classic cycle with its ack timing checks
   task automatic bus_cycle(input string name, input logic we, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
      int waited;
      @(posedge clk);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= we;
      wb_addr  <= mi_addr_t'(addr);
      wb_wdata <= wdata;
      waited = 0;
      do begin
         @(negedge clk);                                    // Sample mid cycle
         waited++;
      end while (!wb_ack && waited < ACK_LIMIT);
      assert (wb_ack) else begin
         fail_run({name, ": no wb_ack arrived for the bus cycle"});
      end
      assert (waited == 2) else begin
         fail_run({name, ": wb_ack did not come one cycle after the strobe"});
      end
      rdata = wb_rdata;                                     // Valid in ack cycle
      @(posedge clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
      @(negedge clk);
      assert (!wb_ack) else begin
         fail_run({name, ": wb_ack stayed high for more than one cycle"});
      end
   endtask

   task automatic pulse_events(input logic [31:0] mask);
      @(posedge clk);
      events <= link_events_t'(mask[EMON_COUNT-1:0]);       // One cycle pulse
      @(posedge clk);
      events <= '0;
   endtask

   // Group 0 holds interrupts and group 1 the link control fields
   task automatic read_flags(input logic [31:0] group, output logic [31:0] word);
      @(posedge clk);
      @(negedge clk);
      if (group == 32'd0) begin
         word = {24'd0, embox_full, embox_not_empty, emon_zero_flag};
      end else begin
         word = {8'd0, clk_cfg, rx_cfg, tx_cfg};
      end
   endtask

   initial begin : watchdog
      wait (line_total > 0);
      #(CLK_PERIOD * (CYCLES_PER_OP * line_total + RESET_CYCLES + 2));
      $display("Timeout: the tests did not finish in the time allowed");
      $display("Test failed");
      $fatal(1);
   end

   initial begin : main
      int          fd;
      int          n;
      int          lines;
      string       line;
      string       name;
      string       op;
      logic [31:0] addr;
      logic [31:0] data;
      logic [31:0] expected;
      logic [31:0] actual;
      rst        <= 1'b1;
      wb_cyc     <= 1'b0;
      wb_stb     <= 1'b0;
      wb_we      <= 1'b0;
      wb_addr    <= '0;
      wb_wdata   <= '0;
      events     <= '0;
      lfsr_state = 16'd30591;
      lines      = 0;
      fd = $fopen(TESTS_FILE, "r");
      if (fd == 0) begin
         fail_run("Could not open the tests file");
      end
      while (!$feof(fd)) begin                              // Size the watchdog
         n = $fgets(line, fd);
         if (n > 0) begin
            lines++;
         end
      end
      $fclose(fd);
      line_total = lines;                                   // Final count in one step
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;
      fd = $fopen(TESTS_FILE, "r");
      while ($fgets(line, fd) > 0) begin
         if (line.len() < 2 || line.substr(0, 0) == "#") begin
            continue;                                       // Blank or column notes
         end
         n = $sscanf(line, "%s %s %h %h %h", name, op, addr, data, expected);
         if (n != 5) begin
            fail_run({"Malformed line in the tests file: ", line});
         end
         idle_gap();
         if (op == "W") begin
            bus_cycle(name, 1'b1, addr, data, actual);
         end else if (op == "R") begin
            bus_cycle(name, 1'b0, addr, 32'd0, actual);
            check_value(name, expected, actual);
         end else if (op == "E") begin
            pulse_events(data);
         end else if (op == "F") begin
            read_flags(addr, actual);
            check_value(name, expected, actual);
         end else begin
            fail_run({"Unknown operation ", op, " in test ", name});
         end
      end
      $fclose(fd);
      $display("Test completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

// File: testbench/elink_ctrl_tests.txt
# name op addr data expected, all hex; W write, R read, E event mask, F flags
# F group 0 is {full, not_empty, zero[5:0]}, group 1 is {clk_cfg, rx_cfg, tx_cfg}
rst_flags      F 0   0        3f
rst_cfg        F 1   0        0
coreid_rd      R 10  0        808
tx_wr          W 4   ffffffff 0
tx_rd          R 4   0        7ff
rx_wr          W 8   a        0
clk_wr         W c   12345    0
clk_rd         R c   0        145
cfg_out        F 1   0        a2d7ff
coreid_wr      W 10  123      0
coreid_ro      R 10  0        808
unmapped_rd    R 100 0        0
mbox_st0       R 24  0        0
mbox_wr0       W 20  a1       0
mbox_wr1       W 20  b2       0
mbox_wr2       W 20  c3       0
mbox_wr3       W 20  d4       0
mbox_full      F 0   0        ff
mbox_st4       R 24  0        4
mbox_drop      W 20  e5       0
mbox_rd0       R 20  0        a1
mbox_st3       R 24  0        3
mbox_part      F 0   0        7f
mbox_rd1       R 20  0        b2
mbox_rd2       R 20  0        c3
mbox_rd3       R 20  0        d4
mbox_empty     F 0   0        3f
mbox_rd_empty  R 20  0        0
mon_ld0        W 40  5        0
mon_ld1        W 44  2        0
mon_ld2        W 48  0        0
mon_ld3        W 4c  100      0
mon_ld4        W 50  1        0
mon_ld5        W 54  3        0
mon_zero0      F 0   0        04
mon_ev_all0    E 0   3f       0
mon_ev_all1    E 0   3f       0
mon_ev_edge    E 0   21       0
mon_c0         R 40  0        2
mon_c1         R 44  0        0
mon_c3         R 4c  0        fe
mon_zero1      F 0   0        36
sw_mail        W 20  77       0
sw_reset       W 0   1        0
sw_flags       F 0   0        3f
sw_c3          R 4c  0        0
sw_cfg         F 1   0        a2d7ff
sw_reset_rd    R 0   0        0
